// File: rtl/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry

// set index bits
`define DCACHE_INDEX_W 4

// word-in-line bits
`define DCACHE_OFFSET_W 2

// data path width
`define DCACHE_WORD_W 32

`define DCACHE_WORDS 4
`define DCACHE_SETS 16

// fixed at two, one lru bit per set
`define DCACHE_WAYS 2

// address bits left above index, word offset and byte offset
`define DCACHE_TAG_W (`DCACHE_WORD_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W - 2)

`endif

// File: rtl/dcache_req_pkg.sv
`include "dcache_consts.svh"

package dcache_req_pkg;

    // load-store stage to cache
    typedef struct packed {
        // 0 read, 1 write
        logic                         we;
        logic [`DCACHE_WORD_W-1:0]    addr;
        logic [`DCACHE_WORD_W-1:0]    wdata;
        // byte lanes for writes
        logic [`DCACHE_WORD_W/8-1:0]  strb;
    } dc_req_t;

    // read data back to the pipeline, always a full word
    typedef struct packed {
        logic                         valid;
        logic [`DCACHE_WORD_W-1:0]    data;
    } dc_rsp_t;

    // one tag array entry
    typedef struct packed {
        logic                         valid;
        logic [`DCACHE_TAG_W-1:0]     tag;
    } dc_tag_t;

    // one data array entry, word 0 in the low bits
    typedef logic [`DCACHE_WORDS-1:0][`DCACHE_WORD_W-1:0] dc_line_t;

endpackage

// File: rtl/dcache_bus_pkg.sv
`include "dcache_consts.svh"

package dcache_bus_pkg;

    // wishbone classic, master side outputs
    typedef struct packed {
        logic                         cyc;
        logic                         stb;
        logic                         we;
        logic [`DCACHE_WORD_W-1:0]    adr;
        logic [`DCACHE_WORD_W-1:0]    dat;
        logic [`DCACHE_WORD_W/8-1:0]  sel;
    } wb_m2s_t;

    // wishbone classic, slave side outputs
    typedef struct packed {
        // one cycle per completed beat
        logic                         ack;
        logic [`DCACHE_WORD_W-1:0]    dat;
    } wb_s2m_t;

endpackage

// File: rtl/dcache_rbuf.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_rbuf (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          load,
    input  dcache_req_pkg::dc_req_t       req,
    output dcache_req_pkg::dc_req_t       buf_req,
    output logic [`DCACHE_TAG_W-1:0]      buf_tag,
    output logic [`DCACHE_INDEX_W-1:0]    buf_index,
    output logic [`DCACHE_OFFSET_W-1:0]   buf_word
);

    // address field positions
    localparam int WORD_LO = 2;
    localparam int IDX_LO  = WORD_LO + `DCACHE_OFFSET_W;
    localparam int TAG_LO  = IDX_LO + `DCACHE_INDEX_W;

    // held through lookup, refill and write-through
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_req <= '0;
        end else if (load) begin
            buf_req <= req;
        end
    end

    assign buf_tag  = buf_req.addr[`DCACHE_WORD_W-1:TAG_LO];
    assign buf_word = buf_req.addr[IDX_LO-1:WORD_LO];

    // array read index follows the incoming request while loading,
    // so the registered array outputs line up with the buffer
    assign buf_index = load ? req.addr[TAG_LO-1:IDX_LO] : buf_req.addr[TAG_LO-1:IDX_LO];

endmodule

// File: rtl/dcache_way_ram.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_way_ram #(
    parameter type entry_t = logic
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          clear,
    input  logic [`DCACHE_INDEX_W-1:0]    rd_index,
    input  logic [`DCACHE_INDEX_W-1:0]    wr_index,
    input  logic                          we,
    input  entry_t                        wr_entry,
    output entry_t                        rd_entry
);

    entry_t mem [`DCACHE_SETS];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    // clear wins over a write to the same entry
    always_ff @(posedge clk) begin
        if (clear) begin
            mem[wr_index] <= '0;
        end else if (we) begin
            mem[wr_index] <= wr_entry;
        end
    end

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////

    // registered, old data on a same-cycle write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_entry <= '0;
        end else begin
            rd_entry <= mem[rd_index];
        end
    end

endmodule

// File: rtl/dcache_lru.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_lru (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [`DCACHE_INDEX_W-1:0]    index,
    input  logic                          touch,
    input  logic                          used_way,
    output logic                          victim
);

    // one bit per set, names the way to replace next
    logic [`DCACHE_SETS-1:0] lru_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;
        end else if (touch) begin
            // point at the other way
            lru_q[index] <= ~used_way;
        end
    end

    assign victim = lru_q[index];

endmodule

// File: rtl/dcache_ctrl.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          req_valid,
    output logic                          req_ready,
    output logic                          rbuf_load,
    input  dcache_req_pkg::dc_req_t       buf_req,
    input  logic [`DCACHE_TAG_W-1:0]      buf_tag,
    input  logic [`DCACHE_INDEX_W-1:0]    buf_index,
    input  logic [`DCACHE_OFFSET_W-1:0]   buf_word,
    input  dcache_req_pkg::dc_tag_t       tag0,
    input  dcache_req_pkg::dc_tag_t       tag1,
    input  dcache_req_pkg::dc_line_t      line0,
    input  dcache_req_pkg::dc_line_t      line1,
    output logic [`DCACHE_WAYS-1:0]       tag_we,
    output logic                          tag_clear,
    output dcache_req_pkg::dc_tag_t       tag_wr,
    output logic [`DCACHE_INDEX_W-1:0]    tag_wr_index,
    output logic [`DCACHE_WAYS-1:0]       line_we,
    output dcache_req_pkg::dc_line_t      line_wr,
    output logic                          lru_touch,
    output logic                          lru_used_way,
    input  logic                          lru_victim,
    output dcache_req_pkg::dc_rsp_t       rsp,
    output dcache_bus_pkg::wb_m2s_t       wb_out,
    input  dcache_bus_pkg::wb_s2m_t       wb_in
);

    import dcache_req_pkg::*;

    typedef enum logic [2:0] {
        ST_CLEAR,
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL,
        ST_FILL_WR,
        ST_WRITE
    } state_t;

    state_t                       state_q;
    state_t                       state_d;
    logic [`DCACHE_INDEX_W-1:0]   sweep_idx;
    logic [`DCACHE_OFFSET_W-1:0]  beat_q;
    dc_line_t                     fill_line;
    dc_line_t                     hit_line;
    dc_line_t                     merged_line;
    logic                         hit0;
    logic                         hit1;
    logic                         hit;
    logic                         hit_way;

    ////////////////////////////////////////////////////////////
    // hit detection and write merge
    ////////////////////////////////////////////////////////////

    assign hit0     = tag0.valid && (tag0.tag == buf_tag);
    assign hit1     = tag1.valid && (tag1.tag == buf_tag);
    assign hit      = hit0 | hit1;
    assign hit_way  = hit1;
    assign hit_line = hit_way ? line1 : line0;

    // strobed bytes of the write land in the cached word
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
            if (buf_req.strb[b]) begin
                merged_line[buf_word][8*b +: 8] = buf_req.wdata[8*b +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_CLEAR:   if (sweep_idx == '1) state_d = ST_IDLE;
            ST_IDLE:    if (req_valid) state_d = ST_LOOKUP;
            ST_LOOKUP: begin
                if (buf_req.we) begin
                    state_d = ST_WRITE;
                end else if (hit) begin
                    state_d = ST_IDLE;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL:  if (wb_in.ack && beat_q == '1) state_d = ST_FILL_WR;
            ST_FILL_WR: state_d = ST_IDLE;
            ST_WRITE:   if (wb_in.ack) state_d = ST_IDLE;
            default:    state_d = ST_CLEAR;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= ST_CLEAR;
            sweep_idx <= '0;
            beat_q    <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_CLEAR) begin
                sweep_idx <= sweep_idx + 1'b1;
            end
            // wraps back to zero after the last beat
            if (state_q == ST_REFILL && wb_in.ack) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // refill line assembly, one word per ack
    always_ff @(posedge clk) begin
        if (state_q == ST_REFILL && wb_in.ack) begin
            fill_line[beat_q] <= wb_in.dat;
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    assign req_ready    = (state_q == ST_IDLE);
    assign rbuf_load    = req_ready && req_valid;
    assign tag_clear    = (state_q == ST_CLEAR);
    assign tag_wr_index = tag_clear ? sweep_idx : buf_index;

    always_comb begin
        tag_we       = '0;
        tag_wr.valid = 1'b1;
        tag_wr.tag   = buf_tag;
        line_we      = '0;
        line_wr      = merged_line;
        lru_touch    = 1'b0;
        lru_used_way = hit_way;
        rsp          = '0;
        wb_out       = '0;
        case (state_q)
            ST_LOOKUP: begin
                lru_touch = hit;
                if (!buf_req.we) begin
                    rsp.valid = hit;
                    rsp.data  = hit_line[buf_word];
                end else if (hit) begin
                    line_we[hit_way] = 1'b1;
                end
            end
            ST_REFILL: begin
                wb_out.cyc = 1'b1;
                wb_out.stb = 1'b1;
                wb_out.adr = {buf_tag, buf_index, beat_q, 2'b00};
                wb_out.sel = '1;
            end
            ST_FILL_WR: begin
                tag_we[lru_victim]  = 1'b1;
                line_we[lru_victim] = 1'b1;
                line_wr             = fill_line;
                lru_touch           = 1'b1;
                lru_used_way        = lru_victim;
                rsp.valid           = 1'b1;
                rsp.data            = fill_line[buf_word];
            end
            ST_WRITE: begin
                wb_out.cyc = 1'b1;
                wb_out.stb = 1'b1;
                wb_out.we  = 1'b1;
                wb_out.adr = buf_req.addr;
                wb_out.dat = buf_req.wdata;
                wb_out.sel = buf_req.strb;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  dcache_req_pkg::dc_req_t       req,
    input  logic                          req_valid,
    output logic                          req_ready,
    output dcache_req_pkg::dc_rsp_t       rsp,
    output dcache_bus_pkg::wb_m2s_t       wb_out,
    input  dcache_bus_pkg::wb_s2m_t       wb_in
);

    import dcache_req_pkg::*;

    logic                         rbuf_load;
    dc_req_t                      buf_req;
    logic [`DCACHE_TAG_W-1:0]     buf_tag;
    logic [`DCACHE_INDEX_W-1:0]   buf_index;
    logic [`DCACHE_OFFSET_W-1:0]  buf_word;
    dc_tag_t                      tag0;
    dc_tag_t                      tag1;
    dc_tag_t                      tag_wr;
    dc_line_t                     line0;
    dc_line_t                     line1;
    dc_line_t                     line_wr;
    logic [`DCACHE_WAYS-1:0]      tag_we;
    logic [`DCACHE_WAYS-1:0]      line_we;
    logic                         tag_clear;
    logic [`DCACHE_INDEX_W-1:0]   tag_wr_index;
    logic                         lru_touch;
    logic                         lru_used_way;
    logic                         lru_victim;

    ////////////////////////////////////////////////////////////
    // request buffer
    ////////////////////////////////////////////////////////////

    // buf_index doubles as the read index of every array,
    // the incoming request while loading and the buffer otherwise
    dcache_rbuf u_rbuf (
        .clk(clk), .arst_n(arst_n), .load(rbuf_load), .req(req),
        .buf_req(buf_req), .buf_tag(buf_tag), .buf_index(buf_index), .buf_word(buf_word)
    );

    ////////////////////////////////////////////////////////////
    // way arrays
    ////////////////////////////////////////////////////////////

    dcache_way_ram #(.entry_t(dc_tag_t)) u_tag0 (
        .clk(clk), .arst_n(arst_n), .clear(tag_clear), .rd_index(buf_index),
        .wr_index(tag_wr_index), .we(tag_we[0]), .wr_entry(tag_wr), .rd_entry(tag0)
    );

    dcache_way_ram #(.entry_t(dc_tag_t)) u_tag1 (
        .clk(clk), .arst_n(arst_n), .clear(tag_clear), .rd_index(buf_index),
        .wr_index(tag_wr_index), .we(tag_we[1]), .wr_entry(tag_wr), .rd_entry(tag1)
    );

    // data lines never need the sweep, their tags gate every use
    dcache_way_ram #(.entry_t(dc_line_t)) u_line0 (
        .clk(clk), .arst_n(arst_n), .clear(1'b0), .rd_index(buf_index),
        .wr_index(tag_wr_index), .we(line_we[0]), .wr_entry(line_wr), .rd_entry(line0)
    );

    dcache_way_ram #(.entry_t(dc_line_t)) u_line1 (
        .clk(clk), .arst_n(arst_n), .clear(1'b0), .rd_index(buf_index),
        .wr_index(tag_wr_index), .we(line_we[1]), .wr_entry(line_wr), .rd_entry(line1)
    );

    dcache_lru u_lru (
        .clk(clk), .arst_n(arst_n), .index(buf_index),
        .touch(lru_touch), .used_way(lru_used_way), .victim(lru_victim)
    );

    ////////////////////////////////////////////////////////////
    // controller and bus master
    ////////////////////////////////////////////////////////////

    dcache_ctrl u_ctrl (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid), .req_ready(req_ready), .rbuf_load(rbuf_load),
        .buf_req(buf_req), .buf_tag(buf_tag), .buf_index(buf_index), .buf_word(buf_word),
        .tag0(tag0), .tag1(tag1), .line0(line0), .line1(line1),
        .tag_we(tag_we), .tag_clear(tag_clear), .tag_wr(tag_wr), .tag_wr_index(tag_wr_index),
        .line_we(line_we), .line_wr(line_wr),
        .lru_touch(lru_touch), .lru_used_way(lru_used_way), .lru_victim(lru_victim),
        .rsp(rsp), .wb_out(wb_out), .wb_in(wb_in)
    );

endmodule

// File: test/wb_mem_model.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module wb_mem_model #(
    parameter int                        WORDS     = 1024,
    parameter logic [`DCACHE_WORD_W-1:0] FILL_BASE = 32'h5a00_0000
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  dcache_bus_pkg::wb_m2s_t       wb_out,
    output dcache_bus_pkg::wb_s2m_t       wb_in
);

    import dcache_bus_pkg::*;

    logic [`DCACHE_WORD_W-1:0] mem [WORDS];
    logic [$clog2(WORDS)-1:0]  widx;
    int                        seed;
    int                        wait_left;

    // every word starts as its own byte address plus a base
    initial begin
        seed = 57;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = FILL_BASE + 32'(i * 4);
        end
    end

    assign widx = wb_out.adr[$clog2(WORDS)+1:2];

    // classic slave, 0 to 3 wait states per beat
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_in     <= '0;
            wait_left <= 0;
        end else begin
            wb_in.ack <= 1'b0;
            if (wb_out.cyc && wb_out.stb && !wb_in.ack) begin
                if (wait_left == 0) begin
                    wb_in.ack <= 1'b1;
                    wb_in.dat <= mem[widx];
                    if (wb_out.we) begin
                        for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
                            if (wb_out.sel[b]) begin
                                mem[widx][8*b +: 8] <= wb_out.dat[8*b +: 8];
                            end
                        end
                    end
                    wait_left <= $random(seed) & 3;
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

endmodule

// File: test/dcache_checker.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_checker (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          req_valid,
    input  logic                          req_ready,
    input  dcache_req_pkg::dc_rsp_t       rsp,
    input  dcache_bus_pkg::wb_m2s_t       wb_out,
    input  dcache_bus_pkg::wb_s2m_t       wb_in,
    output int                            n_checks,
    output int                            n_errors,
    output int                            pending
);

    import dcache_bus_pkg::*;

    localparam int LINE_LO = 2 + `DCACHE_OFFSET_W;

    // one issued request and what it should cause
    typedef struct packed {
        logic                         we;
        logic [`DCACHE_WORD_W-1:0]    addr;
        logic [`DCACHE_WORD_W-1:0]    data;
        logic [`DCACHE_WORD_W/8-1:0]  strb;
        logic [2:0]                   beats;
    } access_t;

    access_t  exp_q [$];
    access_t  cur;
    logic     busy;
    int       beats_seen;
    logic     held;
    wb_m2s_t  held_out;
    // cycles since the last acceptance or completed beat
    int       since_event;

    initial begin
        n_checks    = 0;
        n_errors    = 0;
        pending     = 0;
        busy        = 1'b0;
        beats_seen  = 0;
        held        = 1'b0;
        cur         = '0;
        since_event = 0;
    end

    task automatic expect_access(input logic we, input logic [31:0] addr,
                                 input logic [31:0] data, input logic [3:0] strb,
                                 input int beats);
        access_t a;
        a.we    = we;
        a.addr  = addr;
        a.data  = data;
        a.strb  = strb;
        a.beats = beats[2:0];
        exp_q.push_back(a);
        pending++;
    endtask

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0d ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic fault(input string what);
        n_checks++;
        n_errors++;
        $display("at %0d ns: %s", $time, what);
    endtask

    task automatic finish_access();
        compare("bus beat count", beats_seen, cur.beats);
        busy = 1'b0;
        pending--;
    endtask

    ////////////////////////////////////////////////////////////
    // sampled mid-cycle with all DUT outputs settled
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (arst_n) begin
            since_event++;

            // stalled beat must keep the master outputs still
            if (held) begin
                if (wb_out !== held_out) begin
                    fault("master outputs changed while waiting for ack");
                end else begin
                    n_checks++;
                end
            end
            held     = wb_out.cyc && wb_out.stb && !wb_in.ack;
            held_out = wb_out;

            // refill keeps cyc up between its beats
            if (busy && !cur.we && beats_seen > 0 && beats_seen < `DCACHE_WORDS) begin
                compare("wb_out.cyc", wb_out.cyc, 1'b1);
            end

            // write is done once the cache takes requests again
            // req_ready returns one cycle after the write ack
            if (busy && cur.we && req_ready) begin
                compare("req_ready latency", since_event, 1);
                finish_access();
            end

            if (wb_out.cyc && wb_out.stb && wb_in.ack) begin
                if (!busy) begin
                    fault("bus beat with no request outstanding");
                end else if (cur.we) begin
                    compare("wb_out.we", wb_out.we, 1'b1);
                    compare("wb_out.adr", wb_out.adr, cur.addr);
                    compare("wb_out.dat", wb_out.dat, cur.data);
                    compare("wb_out.sel", wb_out.sel, cur.strb);
                    beats_seen++;
                end else begin
                    // refill walks the line upwards from its base
                    compare("wb_out.we", wb_out.we, 1'b0);
                    compare("wb_out.adr", wb_out.adr,
                            {cur.addr[31:LINE_LO], beats_seen[`DCACHE_OFFSET_W-1:0], 2'b00});
                    compare("wb_out.sel", wb_out.sel, 4'hf);
                    beats_seen++;
                end
                since_event = 0;
            end

            if (rsp.valid) begin
                if (!busy || cur.we) begin
                    fault("read response with no read outstanding");
                end else begin
                    // one cycle after acceptance on a hit, after the last beat on a miss
                    compare("rsp.valid latency", since_event, 1);
                    compare("rsp.data", rsp.data, cur.data);
                    finish_access();
                end
            end

            if (req_valid && req_ready) begin
                if (busy) begin
                    fault("request accepted while another was in flight");
                end
                if (exp_q.size() == 0) begin
                    fault("request accepted that the testbench never issued");
                end else begin
                    cur         = exp_q.pop_front();
                    busy        = 1'b1;
                    beats_seen  = 0;
                    since_event = 0;
                end
            end
        end
    end

endmodule

// File: test/tb_dcache.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module tb_dcache;

    import dcache_req_pkg::*;
    import dcache_bus_pkg::*;

    localparam int          MEM_WORDS = 1024;
    localparam logic [31:0] FILL_BASE = 32'h5a00_0000;
    localparam int          IDX_LO    = 2 + `DCACHE_OFFSET_W;
    localparam int          TAG_LO    = IDX_LO + `DCACHE_INDEX_W;
    // 2 cold, 4 hit, 4 write-through, 6 lru, 200 random
    localparam int          N_REQ       = 216;
    localparam int          CYCLE_LIMIT = 40 * N_REQ;

    logic     clk;
    logic     arst_n;
    dc_req_t  req;
    logic     req_valid;
    logic     req_ready;
    dc_rsp_t  rsp;
    wb_m2s_t  wb_out;
    wb_s2m_t  wb_in;
    int       n_checks;
    int       n_errors;
    int       pending;
    int       cycles;
    int       seed;
    int       checks_at_start;
    int       errors_at_start;

    // memory mirror and cache state mirror
    logic [31:0]              mirror  [MEM_WORDS];
    logic [`DCACHE_TAG_W-1:0] ref_tag [`DCACHE_SETS][`DCACHE_WAYS];
    logic                     ref_vld [`DCACHE_SETS][`DCACHE_WAYS];
    logic                     ref_lru [`DCACHE_SETS];

    dcache_top DUT (
        .clk(clk), .arst_n(arst_n), .req(req), .req_valid(req_valid),
        .req_ready(req_ready), .rsp(rsp), .wb_out(wb_out), .wb_in(wb_in)
    );

    wb_mem_model #(.WORDS(MEM_WORDS), .FILL_BASE(FILL_BASE)) u_mem (
        .clk(clk), .arst_n(arst_n), .wb_out(wb_out), .wb_in(wb_in)
    );

    dcache_checker u_chk (
        .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req_ready(req_ready),
        .rsp(rsp), .wb_out(wb_out), .wb_in(wb_in),
        .n_checks(n_checks), .n_errors(n_errors), .pending(pending)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        return mirror[addr[11:2]];
    endfunction

    // predicts the bus beats of a request and updates the cache mirror
    function automatic int predict_beats(input logic we, input logic [31:0] addr);
        logic [`DCACHE_INDEX_W-1:0] set;
        logic [`DCACHE_TAG_W-1:0]   tag;
        int                         way;
        set = addr[TAG_LO-1:IDX_LO];
        tag = addr[31:TAG_LO];
        way = -1;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (ref_vld[set][w] && ref_tag[set][w] == tag) begin
                way = w;
            end
        end
        if (way >= 0) begin
            // any hit points the lru at the other way
            ref_lru[set] = (way == 0);
            return we ? 1 : 0;
        end
        if (we) begin
            return 1;
        end
        way = ref_lru[set];
        ref_tag[set][way] = tag;
        ref_vld[set][way] = 1'b1;
        ref_lru[set]      = (way == 0);
        return 4;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic issue(input logic we, input logic [31:0] addr,
                         input logic [31:0] data, input logic [3:0] strb);
        int          beats;
        logic [31:0] exp_data;
        beats = predict_beats(we, addr);
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    mirror[addr[11:2]][8*b +: 8] = data[8*b +: 8];
                end
            end
            exp_data = data;
        end else begin
            exp_data = ref_read(addr);
        end
        u_chk.expect_access(we, addr, exp_data, strb, beats);
        req.we    = we;
        req.addr  = addr;
        req.wdata = data;
        req.strb  = strb;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #5;
        req_valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        while (pending != 0) begin
            @(posedge clk);
        end
        $display("%s: %0d checks, %0d errors", name,
                 n_checks - checks_at_start, n_errors - errors_at_start);
        checks_at_start = n_checks;
        errors_at_start = n_errors;
    endtask

    initial begin
        int          tag_sel;
        int          set_sel;
        int          word_sel;
        logic        we;
        logic [3:0]  strb;
        logic [31:0] addr;
        clk             = 1'b0;
        arst_n          = 1'b0;
        req             = '0;
        req_valid       = 1'b0;
        cycles          = 0;
        seed            = 57;
        checks_at_start = 0;
        errors_at_start = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mirror[i] = FILL_BASE + 32'(i * 4);
        end
        for (int s = 0; s < `DCACHE_SETS; s++) begin
            ref_lru[s] = 1'b0;
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                ref_vld[s][w] = 1'b0;
                ref_tag[s][w] = '0;
            end
        end
        repeat (10) @(posedge clk);
        #5;
        arst_n = 1'b1;

        issue(1'b0, 32'h048, '0, '0);
        issue(1'b0, 32'h2a4, '0, '0);
        end_test("cold read");

        for (int w = 0; w < 4; w++) begin
            issue(1'b0, 32'h040 + 32'(4 * w), '0, '0);
        end
        end_test("hit");

        // one write to a cached line and one to an uncached line
        issue(1'b1, 32'h044, 32'hdead_beef, 4'b0110);
        issue(1'b0, 32'h044, '0, '0);
        issue(1'b1, 32'h3c8, 32'h1234_5678, 4'b1111);
        issue(1'b0, 32'h3c8, '0, '0);
        end_test("write-through");

        // tags A B A C in set 5 followed by A hitting and B missing
        issue(1'b0, 32'h050, '0, '0);
        issue(1'b0, 32'h150, '0, '0);
        issue(1'b0, 32'h050, '0, '0);
        issue(1'b0, 32'h250, '0, '0);
        issue(1'b0, 32'h054, '0, '0);
        issue(1'b0, 32'h150, '0, '0);
        end_test("lru eviction");

        // 3 tags over sets 8 to 11
        repeat (200) begin
            tag_sel  = $unsigned($random(seed)) % 3;
            set_sel  = $unsigned($random(seed)) % 4;
            word_sel = $unsigned($random(seed)) % 4;
            we       = 1'($random(seed));
            strb     = 4'($random(seed));
            if (strb == 4'h0) begin
                strb = 4'hf;
            end
            addr = (tag_sel << TAG_LO) | ((8 + set_sel) << IDX_LO) | (word_sel << 2);
            issue(we, addr, $random(seed), strb);
        end
        end_test("random traffic");

        $display("checks passed %0d, errors %0d", n_checks - n_errors, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+rtl
rtl/dcache_req_pkg.sv
rtl/dcache_bus_pkg.sv
rtl/dcache_rbuf.sv
rtl/dcache_way_ram.sv
rtl/dcache_lru.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
test/wb_mem_model.sv
test/dcache_checker.sv
test/tb_dcache.sv
